// File: design/bht_if.sv
`timescale 1ns/1ps
`default_nettype none

// Lookup and update bus between fetch and the history table
interface bht_if;

	// Lookup by the current PC
	logic [fetch_pkg::BHT_INDEX_W-1:0] read_index;
	// Entry returns in the same cycle
	logic [fetch_pkg::BHT_ENTRY_W-1:0] read_entry;

	// Update from the branch resolve stage
	logic [fetch_pkg::BHT_INDEX_W-1:0] write_index;
	logic [fetch_pkg::BHT_ENTRY_W-1:0] write_entry;
	logic write_en;

	// Fetch side drives index and the forwarded update
	modport fetch
	(
		output read_index,
		input read_entry,
		output write_index,
		output write_entry,
		output write_en
	);

	// Storage side
	modport tbl
	(
		input read_index,
		output read_entry,
		input write_index,
		input write_entry,
		input write_en
	);

endinterface

`default_nettype wire

// File: design/branch_history_table.sv
`timescale 1ns/1ps
`default_nettype none

module branch_history_table
(
	input logic clk,
	bht_if.tbl bht
);

	////////////////////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////////////////////

	// One entry per word index
	// Bits 33:32 counter and bits 31:0 target
	// No tag so aliasing PCs share an entry
	logic [fetch_pkg::BHT_ENTRY_W-1:0] entries [fetch_pkg::BHT_DEPTH];

	////////////////////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////////////////////

	// Update lands on the edge
	// Prediction sees it from the next cycle on
	always_ff @(posedge clk)
	begin
		if (bht.write_en)
		begin
			entries[bht.write_index] <= bht.write_entry;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read port
	////////////////////////////////////////////////////////////////////////////

	// Asynchronous read
	// Same-cycle write to this entry is not forwarded
	assign bht.read_entry = entries[bht.read_index];

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// Resolve stage must hand over a clean index with every update
	a_write_index_known : assert property (
		@(posedge clk) bht.write_en |-> !$isunknown(bht.write_index)
	)
	else $error("BHT write with unknown index");

endmodule

`default_nettype wire

// File: design/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Instruction encodings
	////////////////////////////////////////////////////////////////////////////

	// Major opcodes the predecoder looks for
	localparam logic [5:0] OPCODE_R = 6'd0;
	localparam logic [5:0] OPCODE_J = 6'd2;
	localparam logic [5:0] OPCODE_JAL = 6'd3;
	localparam logic [5:0] OPCODE_BEQ = 6'd4;
	localparam logic [5:0] OPCODE_BNE = 6'd5;

	// R-format function code of JR
	localparam logic [5:0] FUNCT_JR = 6'd8;

	// All-zero word that decodes as sll r0 r0 0
	localparam logic [31:0] NOP = 32'h0000_0000;

	// Sequential fetch step in bytes
	localparam logic [31:0] PC_STEP = 32'd4;

	////////////////////////////////////////////////////////////////////////////
	// Branch history table geometry
	////////////////////////////////////////////////////////////////////////////

	// Table address width and depth
	localparam int BHT_INDEX_W = 10;
	localparam int BHT_DEPTH = 1 << BHT_INDEX_W;

	// Word aligned PC so the index starts at bit 2
	localparam int BHT_INDEX_LSB = 2;

	// Entry layout
	// Counter sits on top and the target below it
	localparam int BHT_CNT_W = 2;
	localparam int BHT_TARGET_W = 32;
	localparam int BHT_ENTRY_W = BHT_CNT_W + BHT_TARGET_W;

	////////////////////////////////////////////////////////////////////////////
	// Instruction word views
	////////////////////////////////////////////////////////////////////////////

	// R-format fields
	typedef struct packed
	{
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	// I-format fields
	// J-format target overlays rs rt and imm
	typedef struct packed
	{
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
	} i_fmt_t;

	// Same 32 bits read either way
	typedef union packed
	{
		r_fmt_t r;
		i_fmt_t i;
	} instr_u;

endpackage

`default_nettype wire

// File: design/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
(
	input logic clk,
	input logic rst,
	input fetch_pkg::instr_u instruction,
	input logic hazard,
	input logic flush,
	input logic cache_stall,
	redirect_if.stage redirect,
	bht_if.fetch bht,
	input logic [9:0] bht_write_index,
	input logic [33:0] bht_write_entry,
	input logic bht_write_en,
	output logic [31:0] pc,
	output fetch_pkg::instr_u fetched_instruction,
	output logic [1:0] bht_token
);

	////////////////////////////////////////////////////////////////////////////
	// Pre-decode
	////////////////////////////////////////////////////////////////////////////

	logic is_beq;
	logic is_bne;
	logic is_j;
	logic is_jal;
	logic is_jr;
	logic is_ctrl;

	// Opcode through the I view
	assign is_beq = (instruction.i.opcode == fetch_pkg::OPCODE_BEQ);
	assign is_bne = (instruction.i.opcode == fetch_pkg::OPCODE_BNE);
	assign is_j = (instruction.i.opcode == fetch_pkg::OPCODE_J);
	assign is_jal = (instruction.i.opcode == fetch_pkg::OPCODE_JAL);

	// JR needs the funct field of the R view
	assign is_jr = (instruction.i.opcode == fetch_pkg::OPCODE_R) &&
		(instruction.r.funct == fetch_pkg::FUNCT_JR);

	// Any control transfer may follow the table
	assign is_ctrl = is_beq | is_bne | is_j | is_jal | is_jr;

	////////////////////////////////////////////////////////////////////////////
	// Table lookup and update forwarding
	////////////////////////////////////////////////////////////////////////////

	logic [fetch_pkg::BHT_CNT_W-1:0] pred_cnt;
	logic [fetch_pkg::BHT_TARGET_W-1:0] pred_target;
	logic pred_taken;

	// Index from PC bits 11:2
	assign bht.read_index = pc[fetch_pkg::BHT_INDEX_LSB +: fetch_pkg::BHT_INDEX_W];

	// Split the entry
	assign pred_cnt = bht.read_entry[fetch_pkg::BHT_ENTRY_W-1 -: fetch_pkg::BHT_CNT_W];
	assign pred_target = bht.read_entry[fetch_pkg::BHT_TARGET_W-1:0];

	// Counter MSB means weakly or strongly taken
	assign pred_taken = is_ctrl && pred_cnt[fetch_pkg::BHT_CNT_W-1];

	// Updates come in on top ports and go straight to the table
	assign bht.write_index = bht_write_index;
	assign bht.write_entry = bht_write_entry;
	assign bht.write_en = bht_write_en;

	////////////////////////////////////////////////////////////////////////////
	// Next PC
	////////////////////////////////////////////////////////////////////////////

	logic [31:0] redirect_pc;
	logic [31:0] seq_pc;
	logic [31:0] fetch_pc;
	logic stall;

	// Resolved branch beats jump beats recovery PC
	always_comb
	begin
		if (redirect.branch_taken)
		begin
			redirect_pc = redirect.pc_branch;
		end
		else if (redirect.jump_taken)
		begin
			redirect_pc = redirect.pc_jump;
		end
		else
		begin
			redirect_pc = redirect.pc_next;
		end
	end

	assign seq_pc = pc + fetch_pkg::PC_STEP;

	// Predicted target or fall through
	assign fetch_pc = pred_taken ? pred_target : seq_pc;

	// Either stall source freezes IF/ID
	assign stall = hazard | cache_stall;

	////////////////////////////////////////////////////////////////////////////
	// PC and IF/ID register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc <= '0;
			fetched_instruction <= fetch_pkg::NOP;
			bht_token <= '0;
		end
		// Flush wins even over a stall
		else if (flush)
		begin
			pc <= redirect_pc;
			fetched_instruction <= fetch_pkg::NOP;
			bht_token <= '0;
		end
		// Stall leaves all three untouched
		else if (!stall)
		begin
			pc <= fetch_pc;
			fetched_instruction <= instruction;
			bht_token <= pred_cnt;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// Later stages must drive clean control once out of reset
	a_redirect_known : assert property (
		@(posedge clk) disable iff (rst)
		!$isunknown({flush, redirect.branch_taken, redirect.jump_taken})
	)
	else $error("Flush or redirect token unknown");

	// Flushed slot shows a bubble one cycle later
	a_flush_bubble : assert property (
		@(posedge clk) disable iff (rst)
		flush |=> (fetched_instruction == fetch_pkg::NOP)
	)
	else $error("IF/ID not cleared after flush");

endmodule

`default_nettype wire

// File: design/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top
(
	input logic clk,
	input logic rst,
	input logic [31:0] instruction,
	input logic [31:0] pc_branch,
	input logic [31:0] pc_jump,
	input logic [31:0] pc_next,
	input logic branch_taken,
	input logic jump_taken,
	input logic hazard,
	input logic flush,
	input logic cache_stall,
	input logic [9:0] bht_write_index,
	input logic [33:0] bht_write_entry,
	input logic bht_write_en,
	output logic [31:0] pc,
	output logic [31:0] fetched_instruction,
	output logic [1:0] bht_token
);

	////////////////////////////////////////////////////////////////////////////
	// Internal buses
	////////////////////////////////////////////////////////////////////////////

	bht_if bht_bus ();
	redirect_if redirect_bus ();

	// Redirect inputs onto the bus
	assign redirect_bus.pc_branch = pc_branch;
	assign redirect_bus.pc_jump = pc_jump;
	assign redirect_bus.pc_next = pc_next;
	assign redirect_bus.branch_taken = branch_taken;
	assign redirect_bus.jump_taken = jump_taken;

	////////////////////////////////////////////////////////////////////////////
	// Fetch stage and table
	////////////////////////////////////////////////////////////////////////////

	fetch_stage u_fetch
	(
		.clk (clk),
		.rst (rst),
		.instruction (instruction),
		.hazard (hazard),
		.flush (flush),
		.cache_stall (cache_stall),
		.redirect (redirect_bus.stage),
		.bht (bht_bus.fetch),
		.bht_write_index (bht_write_index),
		.bht_write_entry (bht_write_entry),
		.bht_write_en (bht_write_en),
		.pc (pc),
		.fetched_instruction (fetched_instruction),
		.bht_token (bht_token)
	);

	// Table has no reset
	branch_history_table u_bht
	(
		.clk (clk),
		.bht (bht_bus.tbl)
	);

endmodule

`default_nettype wire

// File: design/redirect_if.sv
`timescale 1ns/1ps
`default_nettype none

// Redirect targets and select tokens from the later stages
interface redirect_if;

	// Resolved branch target
	logic [31:0] pc_branch;
	// Jump target from decode
	logic [31:0] pc_jump;
	// Recovery PC for a mispredicted fall through
	logic [31:0] pc_next;

	// Select tokens
	// Only looked at while flush is high
	logic branch_taken;
	logic jump_taken;

	// Later stages produce
	modport source
	(
		output pc_branch,
		output pc_jump,
		output pc_next,
		output branch_taken,
		output jump_taken
	);

	// Fetch consumes
	modport stage
	(
		input pc_branch,
		input pc_jump,
		input pc_next,
		input branch_taken,
		input jump_taken
	);

endinterface

`default_nettype wire

// File: tb.f
design/fetch_pkg.sv
design/bht_if.sv
design/redirect_if.sv
design/branch_history_table.sv
design/fetch_stage.sv
design/fetch_top.sv
tb/fetch_tb.sv

// File: tb/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 5;
	localparam int MARGIN_CYCLES = 20;
	localparam int SEED = 96330;

	// One applied step of stimulus
	typedef struct
	{
		string name;
		fetch_pkg::instr_u instr;
		logic flush;
		logic hazard;
		logic cache_stall;
		logic branch_taken;
		logic jump_taken;
		logic [31:0] pc_branch;
		logic [31:0] pc_jump;
		logic [31:0] pc_next;
		logic bht_we;
		logic [9:0] bht_index;
		logic [33:0] bht_entry;
	} row_t;

	logic clk;
	logic rst;
	logic [31:0] instruction;
	logic [31:0] pc_branch;
	logic [31:0] pc_jump;
	logic [31:0] pc_next;
	logic branch_taken;
	logic jump_taken;
	logic hazard;
	logic flush;
	logic cache_stall;
	logic [9:0] bht_write_index;
	logic [33:0] bht_write_entry;
	logic bht_write_en;
	logic [31:0] pc;
	logic [31:0] fetched_instruction;
	logic [1:0] bht_token;

	row_t rows[$];
	logic rows_built = 1'b0;

	// Reference model state
	logic [31:0] exp_pc;
	fetch_pkg::instr_u exp_instr;
	logic [1:0] exp_token;
	logic [33:0] shadow [fetch_pkg::BHT_DEPTH];

	fetch_top dut0
	(
		.clk (clk),
		.rst (rst),
		.instruction (instruction),
		.pc_branch (pc_branch),
		.pc_jump (pc_jump),
		.pc_next (pc_next),
		.branch_taken (branch_taken),
		.jump_taken (jump_taken),
		.hazard (hazard),
		.flush (flush),
		.cache_stall (cache_stall),
		.bht_write_index (bht_write_index),
		.bht_write_entry (bht_write_entry),
		.bht_write_en (bht_write_en),
		.pc (pc),
		.fetched_instruction (fetched_instruction),
		.bht_token (bht_token)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Instruction and address generators
	////////////////////////////////////////////////////////////////////////////

	// Branch or jump with random fields
	function automatic fetch_pkg::instr_u make_ctrl(logic [5:0] opcode);
		logic [31:0] r;
		r = $urandom();
		return {opcode, r[25:0]};
	endfunction

	// JR rs as R format with funct 8
	function automatic fetch_pkg::instr_u make_jr();
		logic [31:0] r;
		r = $urandom();
		return {fetch_pkg::OPCODE_R, r[4:0], 15'd0, fetch_pkg::FUNCT_JR};
	endfunction

	// ADD rd rs rt
	function automatic fetch_pkg::instr_u make_add();
		logic [31:0] r;
		r = $urandom();
		return {fetch_pkg::OPCODE_R, r[14:0], 5'd0, 6'h20};
	endfunction

	// LW with opcode 0x23
	function automatic fetch_pkg::instr_u make_lw();
		logic [31:0] r;
		r = $urandom();
		return {6'h23, r[25:0]};
	endfunction

	// Filler never transfers control
	function automatic fetch_pkg::instr_u rand_filler();
		logic [31:0] r;
		r = $urandom();
		return r[0] ? make_add() : make_lw();
	endfunction

	function automatic logic [31:0] rand_target();
		logic [31:0] r;
		r = $urandom();
		return {r[31:2], 2'b00};
	endfunction

	// Preload pattern hashed over the whole index
	// Counter MSB clear so the preload never predicts taken
	// Counter LSB alternates so neighboring entries differ
	function automatic logic [33:0] fill_entry(int unsigned idx);
		logic [31:0] h;
		logic [9:0] i;
		i = idx[9:0];
		h = idx * 32'h0001_0041 + 32'h0000_1000;
		return {1'b0, i[0], h[29:0], 2'b00};
	endfunction

	// Control transfers that may follow the table
	function automatic logic is_control(fetch_pkg::instr_u w);
		return (w.i.opcode == fetch_pkg::OPCODE_BEQ) ||
			(w.i.opcode == fetch_pkg::OPCODE_BNE) ||
			(w.i.opcode == fetch_pkg::OPCODE_J) ||
			(w.i.opcode == fetch_pkg::OPCODE_JAL) ||
			((w.i.opcode == fetch_pkg::OPCODE_R) && (w.r.funct == fetch_pkg::FUNCT_JR));
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////////////////////////////////////////

	// Redirect inputs random as they matter only under flush
	function automatic row_t new_row(string name);
		row_t r;
		logic [31:0] bits;
		bits = $urandom();
		r.name = name;
		r.instr = rand_filler();
		r.flush = 1'b0;
		r.hazard = 1'b0;
		r.cache_stall = 1'b0;
		r.branch_taken = bits[0];
		r.jump_taken = bits[1];
		r.pc_branch = rand_target();
		r.pc_jump = rand_target();
		r.pc_next = rand_target();
		r.bht_we = 1'b0;
		r.bht_index = '0;
		r.bht_entry = '0;
		return r;
	endfunction

	task automatic seq_row(string name, fetch_pkg::instr_u instr);
		row_t r;
		r = new_row(name);
		r.instr = instr;
		rows.push_back(r);
	endtask

	task automatic redirect_row(string name, fetch_pkg::instr_u instr, logic bt, logic jt,
		logic hz, logic cs);
		row_t r;
		r = new_row(name);
		r.instr = instr;
		r.flush = 1'b1;
		r.branch_taken = bt;
		r.jump_taken = jt;
		r.hazard = hz;
		r.cache_stall = cs;
		rows.push_back(r);
	endtask

	task automatic stall_row(string name, logic hz, logic cs);
		row_t r;
		r = new_row(name);
		r.instr = make_ctrl(fetch_pkg::OPCODE_BEQ);
		r.hazard = hz;
		r.cache_stall = cs;
		rows.push_back(r);
	endtask

	// Flush to a fresh PC and write its entry on the same edge
	task automatic preload_row(string name, logic [1:0] cnt);
		row_t r;
		r = new_row(name);
		r.flush = 1'b1;
		r.branch_taken = 1'b0;
		r.jump_taken = 1'b0;
		r.bht_we = 1'b1;
		r.bht_index = r.pc_next[fetch_pkg::BHT_INDEX_LSB +: fetch_pkg::BHT_INDEX_W];
		r.bht_entry = {cnt, rand_target()};
		rows.push_back(r);
	endtask

	task automatic build_rows();
		// Sequential fetch
		for (int i = 0; i < 6; i++)
		begin
			seq_row("sequential", rand_filler());
		end
		seq_row("branch on preload", make_ctrl(fetch_pkg::OPCODE_BEQ));
		seq_row("sequential", rand_filler());

		// Redirect priority
		redirect_row("flush both tokens", make_ctrl(fetch_pkg::OPCODE_J), 1, 1, 0, 0);
		seq_row("after flush", rand_filler());
		redirect_row("flush jump token", rand_filler(), 0, 1, 0, 0);
		redirect_row("flush no token", make_ctrl(fetch_pkg::OPCODE_JAL), 0, 0, 0, 0);
		seq_row("after flush", rand_filler());

		// Stalls
		for (int i = 0; i < 3; i++)
		begin
			stall_row("hazard", 1, 0);
		end
		seq_row("after hazard", rand_filler());
		for (int i = 0; i < 3; i++)
		begin
			stall_row("cache stall", 0, 1);
		end
		seq_row("after cache stall", rand_filler());
		for (int i = 0; i < 3; i++)
		begin
			stall_row("both stalls", 1, 1);
		end
		redirect_row("flush during stall", rand_filler(), 1, 0, 1, 1);
		seq_row("after stall flush", rand_filler());

		// Taken predictions
		preload_row("preload beq", 2'd2);
		seq_row("predict beq", make_ctrl(fetch_pkg::OPCODE_BEQ));
		preload_row("preload bne", 2'd3);
		seq_row("predict bne", make_ctrl(fetch_pkg::OPCODE_BNE));
		preload_row("preload j", 2'd2);
		seq_row("predict j", make_ctrl(fetch_pkg::OPCODE_J));
		preload_row("preload jal", 2'd3);
		seq_row("predict jal", make_ctrl(fetch_pkg::OPCODE_JAL));
		preload_row("preload jr", 2'd2);
		seq_row("predict jr", make_jr());
		seq_row("after prediction", rand_filler());

		// Not taken
		preload_row("preload weak beq", 2'd0);
		seq_row("no predict beq", make_ctrl(fetch_pkg::OPCODE_BEQ));
		preload_row("preload weak bne", 2'd1);
		seq_row("no predict bne", make_ctrl(fetch_pkg::OPCODE_BNE));
		preload_row("preload add", 2'd3);
		seq_row("add ignores table", make_add());
		preload_row("preload lw", 2'd3);
		seq_row("lw ignores table", make_lw());
		seq_row("final", rand_filler());
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model and checks
	////////////////////////////////////////////////////////////////////////////

	task automatic apply_row(row_t r);
		instruction = r.instr;
		flush = r.flush;
		hazard = r.hazard;
		cache_stall = r.cache_stall;
		branch_taken = r.branch_taken;
		jump_taken = r.jump_taken;
		pc_branch = r.pc_branch;
		pc_jump = r.pc_jump;
		pc_next = r.pc_next;
		bht_write_en = r.bht_we;
		bht_write_index = r.bht_index;
		bht_write_entry = r.bht_entry;
	endtask

	// Flush, then stall, then prediction, then pc + 4
	task automatic model_step(row_t r);
		logic [33:0] entry;
		entry = shadow[exp_pc[fetch_pkg::BHT_INDEX_LSB +: fetch_pkg::BHT_INDEX_W]];
		if (r.flush)
		begin
			if (r.branch_taken)
			begin
				exp_pc = r.pc_branch;
			end
			else if (r.jump_taken)
			begin
				exp_pc = r.pc_jump;
			end
			else
			begin
				exp_pc = r.pc_next;
			end
			exp_instr = fetch_pkg::NOP;
			exp_token = 2'd0;
		end
		else if (!(r.hazard || r.cache_stall))
		begin
			if (is_control(r.instr) && entry[33])
			begin
				exp_pc = entry[31:0];
			end
			else
			begin
				exp_pc = exp_pc + 32'd4;
			end
			exp_instr = r.instr;
			exp_token = entry[33:32];
		end
		// Write lands after the read of this cycle
		if (r.bht_we)
		begin
			shadow[r.bht_index] = r.bht_entry;
		end
	endtask

	task automatic check_pc(string name, logic [31:0] exp, logic [31:0] act);
		if (act !== exp)
		begin
			$display("FAILED %s: pc expected %h actual %h", name, exp, act);
			$display("Simulation finished: FAIL");
			$fatal(1, "pc mismatch");
		end
	endtask

	task automatic check_instr(string name, fetch_pkg::instr_u exp, fetch_pkg::instr_u act);
		if (act !== exp)
		begin
			$display("FAILED %s: instruction expected %h actual %h", name, exp, act);
			$display("Simulation finished: FAIL");
			$fatal(1, "instruction mismatch");
		end
	endtask

	task automatic check_token(string name, logic [1:0] exp, logic [1:0] act);
		if (act !== exp)
		begin
			$display("FAILED %s: token expected %h actual %h", name, exp, act);
			$display("Simulation finished: FAIL");
			$fatal(1, "token mismatch");
		end
	endtask

	task automatic check_outputs(string name);
		check_pc(name, exp_pc, pc);
		check_instr(name, exp_instr, fetched_instruction);
		check_token(name, exp_token, bht_token);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		void'($urandom(SEED));
		rst = 1'b1;
		apply_row(new_row("idle"));
		flush = 1'b0;
		bht_write_en = 1'b0;
		build_rows();
		rows_built = 1'b1;

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		exp_pc = '0;
		exp_instr = fetch_pkg::NOP;
		exp_token = 2'd0;
		check_outputs("reset");

		// Table has no reset so every entry gets a value under hazard
		hazard = 1'b1;
		for (int idx = 0; idx < fetch_pkg::BHT_DEPTH; idx++)
		begin
			bht_write_en = 1'b1;
			bht_write_index = idx[9:0];
			bht_write_entry = fill_entry(idx);
			shadow[idx] = fill_entry(idx);
			@(negedge clk);
		end
		bht_write_en = 1'b0;
		hazard = 1'b0;
		check_outputs("hold during preload");

		// One row per cycle sampled at the falling edge
		foreach (rows[i])
		begin
			apply_row(rows[i]);
			model_step(rows[i]);
			@(negedge clk);
			check_outputs(rows[i].name);
		end

		$display("Simulation finished: PASS");
		$finish;
	end

	// Watchdog sized from the row count and the table preload
	initial
	begin
		int unsigned cycles;
		wait (rows_built);
		cycles = rows.size() + fetch_pkg::BHT_DEPTH + RESET_CYCLES + MARGIN_CYCLES;
		#(cycles * CLK_PERIOD);
		$display("Timeout: the test sequence did not complete in time");
		$display("Simulation finished: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire
